/* Makefile */
SIM       := verilator
TOP       := eth_loopback_tb
FILE_LIST := all.f
BUILD_DIR := obj_dir
SIM_FLAGS := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(BUILD_DIR)
RUN_ARGS  := +verilator+error+limit+100
PASS_TEXT := Simulation completed successfully

SOURCES := $(shell grep -v '^+' $(FILE_LIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILE_LIST)
	$(SIM) $(SIM_FLAGS) -f $(FILE_LIST)

run: $(BIN)
	@out="$$(./$(BIN) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* all.f */
logic/eth_loopback_pkg.sv
logic/rx_frame_check.sv
logic/frame_fifo.sv
logic/tx_frame_gap.sv
logic/stat_counters.sv
logic/eth_loopback_top.sv
verification/eth_loopback_props.sv
verification/eth_loopback_tb.sv

/* logic/eth_loopback_pkg.sv */
// Ethernet loopback shared constants, stream and event structs, and counter register map
package eth_loopback_pkg;

    // Frame sizes, scaled down for simulation
    localparam int MIN_FRAME_LEN = 16;
    localparam int MAX_FRAME_LEN = 256;
    localparam int FIFO_DEPTH    = 512;
    localparam int FIFO_ADDR_W   = 9;
    localparam int IFG_CYCLES    = 12;
    localparam int LEN_W         = 16;

    // Statistics and host bus
    localparam int STAT_W      = 32;
    localparam int STAT_COUNT  = 6;
    localparam int AXIL_ADDR_W = 8;
    localparam int AXIL_DATA_W = 32;

    // Counter indices, byte address is index times 4
    localparam int STAT_RX_GOOD     = 0;
    localparam int STAT_RX_RUNT     = 1;
    localparam int STAT_RX_OVERSIZE = 2;
    localparam int STAT_DROP_BAD    = 3;
    localparam int STAT_DROP_FULL   = 4;
    localparam int STAT_TX_FRAME    = 5;

    // AXI response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef struct packed {
        logic [7:0] data;
        logic       last;
        logic       bad;
    } frame_beat_t;

    // Declared high to low so that bit n is counter n
    typedef struct packed {
        logic tx_frame;
        logic drop_full;
        logic drop_bad;
        logic rx_oversize;
        logic rx_runt;
        logic rx_good;
    } stat_event_t;

    typedef struct packed {
        logic [AXIL_ADDR_W-1:0]   awaddr;
        logic                     awvalid;
        logic [AXIL_DATA_W-1:0]   wdata;
        logic [AXIL_DATA_W/8-1:0] wstrb;
        logic                     wvalid;
        logic                     bready;
        logic [AXIL_ADDR_W-1:0]   araddr;
        logic                     arvalid;
        logic                     rready;
    } axil_req_t;

    typedef struct packed {
        logic                   awready;
        logic                   wready;
        logic [1:0]             bresp;
        logic                   bvalid;
        logic                   arready;
        logic [AXIL_DATA_W-1:0] rdata;
        logic [1:0]             rresp;
        logic                   rvalid;
    } axil_rsp_t;

endpackage

/* logic/eth_loopback_top.sv */
// Ethernet loopback top: frame checker, frame FIFO, gap-enforcing transmitter and counters
`resetall
`timescale 1ns/1ps
`default_nettype none

module eth_loopback_top (
    input  wire logic                          clk,
    input  wire logic                          rst_n,

    // Receive stream
    input  wire eth_loopback_pkg::frame_beat_t rx_beat,
    input  wire logic                          rx_valid,

    // Transmit stream handshake
    input  wire logic                          tx_ready,

    // Host register access
    input  wire eth_loopback_pkg::axil_req_t   axil_req,

    output wire eth_loopback_pkg::frame_beat_t tx_beat,
    output wire logic                          tx_valid,
    output wire eth_loopback_pkg::axil_rsp_t   axil_rsp
);

import eth_loopback_pkg::*;

frame_beat_t chk_beat;
logic        chk_valid;
frame_beat_t fifo_beat;
logic        fifo_valid;
logic        fifo_ready;

logic        ev_good;
logic        ev_runt;
logic        ev_oversize;
logic        ev_drop_bad;
logic        ev_drop_full;
logic        ev_tx_frame;
stat_event_t events;

always_comb begin
    events.rx_good     = ev_good;
    events.rx_runt     = ev_runt;
    events.rx_oversize = ev_oversize;
    events.drop_bad    = ev_drop_bad;
    events.drop_full   = ev_drop_full;
    events.tx_frame    = ev_tx_frame;
end

rx_frame_check rx_frame_check_inst (
    .clk(clk),
    .rst_n(rst_n),
    .rx_beat(rx_beat),
    .rx_valid(rx_valid),
    .chk_beat(chk_beat),
    .chk_valid(chk_valid),
    .ev_good(ev_good),
    .ev_runt(ev_runt),
    .ev_oversize(ev_oversize)
);

frame_fifo frame_fifo_inst (
    .clk(clk),
    .rst_n(rst_n),
    .wr_beat(chk_beat),
    .wr_valid(chk_valid),
    .rd_beat(fifo_beat),
    .rd_valid(fifo_valid),
    .rd_ready(fifo_ready),
    .ev_drop_bad(ev_drop_bad),
    .ev_drop_full(ev_drop_full)
);

tx_frame_gap tx_frame_gap_inst (
    .clk(clk),
    .rst_n(rst_n),
    .in_beat(fifo_beat),
    .in_valid(fifo_valid),
    .in_ready(fifo_ready),
    .tx_beat(tx_beat),
    .tx_valid(tx_valid),
    .tx_ready(tx_ready),
    .ev_tx_frame(ev_tx_frame)
);

stat_counters stat_counters_inst (
    .clk(clk),
    .rst_n(rst_n),
    .events(events),
    .axil_req(axil_req),
    .axil_rsp(axil_rsp)
);

endmodule

`resetall

/* logic/frame_fifo.sv */
// Store-and-forward frame FIFO that commits good frames and drops bad or overflowing ones
`resetall
`timescale 1ns/1ps
`default_nettype none

module frame_fifo (
    input  wire logic                          clk,
    input  wire logic                          rst_n,

    // Write side, always accepted
    input  wire eth_loopback_pkg::frame_beat_t wr_beat,
    input  wire logic                          wr_valid,

    // Read side, committed frames only
    output eth_loopback_pkg::frame_beat_t      rd_beat,
    output logic                               rd_valid,
    input  wire logic                          rd_ready,

    // Drop strobes, one cycle after the last beat of a dropped frame
    output logic                               ev_drop_bad,
    output logic                               ev_drop_full
);

import eth_loopback_pkg::*;

frame_beat_t mem [FIFO_DEPTH];

// Pointers carry one extra bit to tell full from empty
logic [FIFO_ADDR_W:0] wr_ptr;
logic [FIFO_ADDR_W:0] commit_ptr;
logic [FIFO_ADDR_W:0] rd_ptr;
logic [FIFO_ADDR_W:0] used;
logic                 full;
logic                 overflow_drop;
logic                 bad_last;
logic                 wr_store;
logic                 rd_take;

always_comb begin
    // Occupancy includes the uncommitted part of the current frame
    used     = wr_ptr - rd_ptr;
    full     = used == (FIFO_ADDR_W + 1)'(FIFO_DEPTH);
    bad_last = wr_beat.last && wr_beat.bad;
    wr_store = wr_valid && !overflow_drop && !full && !bad_last;
    rd_valid = rd_ptr != commit_ptr;
    rd_take  = rd_valid && rd_ready;
    rd_beat  = mem[rd_ptr[FIFO_ADDR_W-1:0]];
end

always_ff @(posedge clk) begin
    if (wr_store) begin
        mem[wr_ptr[FIFO_ADDR_W-1:0]] <= wr_beat;
    end
end

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        wr_ptr        <= '0;
        commit_ptr    <= '0;
        rd_ptr        <= '0;
        overflow_drop <= 1'b0;
        ev_drop_bad   <= 1'b0;
        ev_drop_full  <= 1'b0;
    end else begin
        ev_drop_bad  <= 1'b0;
        ev_drop_full <= 1'b0;

        if (rd_take) begin
            rd_ptr <= rd_ptr + 1'b1;
        end

        if (wr_valid) begin
            if (bad_last) begin
                // A bad verdict outranks an overflow
                wr_ptr        <= commit_ptr;
                overflow_drop <= 1'b0;
                ev_drop_bad   <= 1'b1;
            end else if (overflow_drop) begin
                if (wr_beat.last) begin
                    overflow_drop <= 1'b0;
                    ev_drop_full  <= 1'b1;
                end
            end else if (full) begin
                // Out of room, discard everything written for this frame
                wr_ptr <= commit_ptr;
                if (wr_beat.last) begin
                    ev_drop_full <= 1'b1;
                end else begin
                    overflow_drop <= 1'b1;
                end
            end else if (wr_beat.last) begin
                wr_ptr     <= wr_ptr + 1'b1;
                commit_ptr <= wr_ptr + 1'b1;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end
end

endmodule

`resetall

/* logic/rx_frame_check.sv */
// Receive frame checker: counts frame length, flags runts, truncates and flags oversize frames
`resetall
`timescale 1ns/1ps
`default_nettype none

module rx_frame_check (
    input  wire logic                          clk,
    input  wire logic                          rst_n,

    // Receive stream, cannot be stalled
    input  wire eth_loopback_pkg::frame_beat_t rx_beat,
    input  wire logic                          rx_valid,

    // Checked stream towards the frame FIFO
    output eth_loopback_pkg::frame_beat_t      chk_beat,
    output logic                               chk_valid,

    // Per-frame statistics strobes
    output logic                               ev_good,
    output logic                               ev_runt,
    output logic                               ev_oversize
);

import eth_loopback_pkg::*;

// Bytes already passed in the current frame
logic [LEN_W-1:0] len_cnt;
logic [LEN_W-1:0] len_next;
logic             discard;
logic             at_limit;
logic             is_runt;

always_comb begin
    len_next = len_cnt + LEN_W'(1);
    // This beat would be byte MAX_FRAME_LEN + 1
    at_limit = len_cnt == LEN_W'(MAX_FRAME_LEN);
    is_runt  = len_next < LEN_W'(MIN_FRAME_LEN);
end

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        chk_valid   <= 1'b0;
        ev_good     <= 1'b0;
        ev_runt     <= 1'b0;
        ev_oversize <= 1'b0;
        len_cnt     <= '0;
        discard     <= 1'b0;
    end else begin
        chk_valid   <= 1'b0;
        ev_good     <= 1'b0;
        ev_runt     <= 1'b0;
        ev_oversize <= 1'b0;
        if (rx_valid) begin
            if (discard) begin
                // Swallow the tail of a truncated frame
                if (rx_beat.last) begin
                    discard <= 1'b0;
                end
            end else if (at_limit) begin
                chk_valid   <= 1'b1;
                ev_oversize <= 1'b1;
                len_cnt     <= '0;
                discard     <= !rx_beat.last;
            end else if (rx_beat.last) begin
                chk_valid <= 1'b1;
                ev_runt   <= is_runt;
                ev_good   <= !is_runt && !rx_beat.bad;
                len_cnt   <= '0;
            end else begin
                chk_valid <= 1'b1;
                len_cnt   <= len_next;
            end
        end
    end
end

// Beat payload, qualified by chk_valid
always_ff @(posedge clk) begin
    if (rx_valid) begin
        chk_beat.data <= rx_beat.data;
        chk_beat.last <= rx_beat.last || at_limit;
        chk_beat.bad  <= at_limit || (rx_beat.last && (rx_beat.bad || is_runt));
    end
end

endmodule

`resetall

/* logic/stat_counters.sv */
// Statistics counter bank, read and cleared by a host over an AXI4-Lite slave
`resetall
`timescale 1ns/1ps
`default_nettype none

module stat_counters (
    input  wire logic                          clk,
    input  wire logic                          rst_n,

    // One increment strobe per counter
    input  wire eth_loopback_pkg::stat_event_t events,

    // Host register access
    input  wire eth_loopback_pkg::axil_req_t   axil_req,
    output eth_loopback_pkg::axil_rsp_t        axil_rsp
);

import eth_loopback_pkg::*;

logic [STAT_COUNT-1:0][STAT_W-1:0] cnt;
logic [STAT_COUNT-1:0]             inc;
logic [STAT_COUNT-1:0]             clr;

// Write channel state
logic                     aw_full;
logic                     w_full;
logic [AXIL_ADDR_W-1:0]   aw_addr_q;
logic [AXIL_DATA_W/8-1:0] w_strb_q;
logic [AXIL_ADDR_W-1:0]   wr_addr;
logic [AXIL_DATA_W/8-1:0] wr_strb;
logic                     awready;
logic                     wready;
logic                     aw_take;
logic                     w_take;
logic                     do_write;
logic                     bvalid;
logic [1:0]               bresp;

// Read channel state
logic                   arready;
logic                   ar_take;
logic                   rvalid;
logic [1:0]             rresp;
logic [AXIL_DATA_W-1:0] rdata;
logic [AXIL_DATA_W-1:0] rd_word;

function automatic logic addr_mapped(input logic [AXIL_ADDR_W-1:0] addr);
    return addr[AXIL_ADDR_W-1:2] < (AXIL_ADDR_W - 2)'(STAT_COUNT);
endfunction

always_comb begin
    inc     = events;
    awready = !aw_full && !bvalid;
    wready  = !w_full && !bvalid;
    arready = !rvalid;
    aw_take = axil_req.awvalid && awready;
    w_take  = axil_req.wvalid && wready;
    ar_take = axil_req.arvalid && arready;

    // Address and data may arrive in either order
    wr_addr  = aw_take ? axil_req.awaddr : aw_addr_q;
    wr_strb  = w_take ? axil_req.wstrb : w_strb_q;
    do_write = (aw_full || aw_take) && (w_full || w_take);

    rd_word = '0;
    for (int n = 0; n < STAT_COUNT; n++) begin
        clr[n] = do_write && &wr_strb && (wr_addr[AXIL_ADDR_W-1:2] == n);
        if (axil_req.araddr[AXIL_ADDR_W-1:2] == n) begin
            rd_word = cnt[n];
        end
    end
end

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        cnt <= '0;
    end else begin
        for (int n = 0; n < STAT_COUNT; n++) begin
            // Clear beats a simultaneous increment
            if (clr[n]) begin
                cnt[n] <= '0;
            end else if (inc[n]) begin
                cnt[n] <= cnt[n] + 1'b1;
            end
        end
    end
end

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        aw_full <= 1'b0;
        w_full  <= 1'b0;
        bvalid  <= 1'b0;
        rvalid  <= 1'b0;
    end else begin
        if (do_write) begin
            aw_full <= 1'b0;
            w_full  <= 1'b0;
            bvalid  <= 1'b1;
        end else begin
            aw_full <= aw_full || aw_take;
            w_full  <= w_full || w_take;
            if (bvalid && axil_req.bready) begin
                bvalid <= 1'b0;
            end
        end

        if (ar_take) begin
            rvalid <= 1'b1;
        end else if (rvalid && axil_req.rready) begin
            rvalid <= 1'b0;
        end
    end
end

// Held address, strobes and response payloads
always_ff @(posedge clk) begin
    if (aw_take) begin
        aw_addr_q <= axil_req.awaddr;
    end
    if (w_take) begin
        w_strb_q <= axil_req.wstrb;
    end
    if (do_write) begin
        bresp <= addr_mapped(wr_addr) ? RESP_OKAY : RESP_SLVERR;
    end
    if (ar_take) begin
        rresp <= addr_mapped(axil_req.araddr) ? RESP_OKAY : RESP_SLVERR;
        rdata <= addr_mapped(axil_req.araddr) ? rd_word : '0;
    end
end

always_comb begin
    axil_rsp.awready = awready;
    axil_rsp.wready  = wready;
    axil_rsp.bresp   = bresp;
    axil_rsp.bvalid  = bvalid;
    axil_rsp.arready = arready;
    axil_rsp.rdata   = rdata;
    axil_rsp.rresp   = rresp;
    axil_rsp.rvalid  = rvalid;
end

endmodule

`resetall

/* logic/tx_frame_gap.sv */
// Transmit stage that forwards frames and holds the inter-frame gap after each one
`resetall
`timescale 1ns/1ps
`default_nettype none

module tx_frame_gap (
    input  wire logic                          clk,
    input  wire logic                          rst_n,

    // Frames from the FIFO
    input  wire eth_loopback_pkg::frame_beat_t in_beat,
    input  wire logic                          in_valid,
    output logic                               in_ready,

    // Transmit stream
    output eth_loopback_pkg::frame_beat_t      tx_beat,
    output logic                               tx_valid,
    input  wire logic                          tx_ready,

    output logic                               ev_tx_frame
);

import eth_loopback_pkg::*;

// Idle cycles left before the next frame may start
logic [$clog2(IFG_CYCLES + 1)-1:0] gap_cnt;
logic                              gap_open;

always_comb begin
    gap_open    = gap_cnt == '0;
    tx_valid    = in_valid && gap_open;
    in_ready    = tx_ready && gap_open;
    tx_beat     = in_beat;
    tx_beat.bad = 1'b0;
    ev_tx_frame = in_valid && tx_ready && gap_open && in_beat.last;
end

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        gap_cnt <= '0;
    end else if (ev_tx_frame) begin
        gap_cnt <= $bits(gap_cnt)'(IFG_CYCLES);
    end else if (!gap_open) begin
        gap_cnt <= gap_cnt - 1'b1;
    end
end

endmodule

`resetall

/* verification/eth_loopback_props.sv */
// Loopback property checker for transmit stall, inter-frame gap, reset and AXI4-Lite responses
`timescale 1ns/1ps

module eth_loopback_props (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire eth_loopback_pkg::frame_beat_t tx_beat,
    input  wire logic                          tx_valid,
    input  wire logic                          tx_ready,
    input  wire eth_loopback_pkg::axil_req_t   axil_req,
    input  wire eth_loopback_pkg::axil_rsp_t   axil_rsp
);

import eth_loopback_pkg::*;

// Number of assertion failures so far
int fail_count = 0;

// Gap cycles still owed after an accepted last beat
logic [$clog2(IFG_CYCLES + 1)-1:0] gap_left;

// Address class of the last accepted read and write
logic rd_mapped;
logic wr_mapped;

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        gap_left <= '0;
    end else if (tx_valid && tx_ready && tx_beat.last) begin
        gap_left <= $bits(gap_left)'(IFG_CYCLES);
    end else if (gap_left != '0) begin
        gap_left <= gap_left - 1'b1;
    end
end

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        rd_mapped <= 1'b0;
        wr_mapped <= 1'b0;
    end else begin
        if (axil_req.arvalid && axil_rsp.arready) begin
            rd_mapped <= axil_req.araddr[AXIL_ADDR_W-1:2] < (AXIL_ADDR_W - 2)'(STAT_COUNT);
        end
        if (axil_req.awvalid && axil_rsp.awready) begin
            wr_mapped <= axil_req.awaddr[AXIL_ADDR_W-1:2] < (AXIL_ADDR_W - 2)'(STAT_COUNT);
        end
    end
end

stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
    tx_valid && !tx_ready |=> tx_valid && $stable(tx_beat))
    else begin
        fail_count = fail_count + 1;
        $error("Transmit beat changed or was withdrawn while stalled");
    end

gap_idle: assert property (@(posedge clk) disable iff (!rst_n)
    gap_left != '0 |-> !tx_valid)
    else begin
        fail_count = fail_count + 1;
        $error("Transmit valid raised inside the inter-frame gap");
    end

reset_idle: assert property (@(posedge clk) !rst_n |-> !tx_valid)
    else begin
        fail_count = fail_count + 1;
        $error("Transmit valid high during reset");
    end

// OKAY for a counter address and SLVERR with zero data elsewhere
bresp_legal: assert property (@(posedge clk) disable iff (!rst_n)
    axil_rsp.bvalid |-> (axil_rsp.bresp == (wr_mapped ? RESP_OKAY : RESP_SLVERR)))
    else begin
        fail_count = fail_count + 1;
        $error("Write response code does not match the address decode");
    end

rresp_legal: assert property (@(posedge clk) disable iff (!rst_n)
    axil_rsp.rvalid
    |-> (axil_rsp.rresp == (rd_mapped ? RESP_OKAY : RESP_SLVERR))
        && (rd_mapped || axil_rsp.rdata == '0))
    else begin
        fail_count = fail_count + 1;
        $error("Read response code or data does not match the address decode");
    end

bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid && $stable(axil_rsp.bresp))
    else begin
        fail_count = fail_count + 1;
        $error("Write response dropped or changed before bready");
    end

rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    axil_rsp.rvalid && !axil_req.rready
    |=> axil_rsp.rvalid && $stable(axil_rsp.rdata) && $stable(axil_rsp.rresp))
    else begin
        fail_count = fail_count + 1;
        $error("Read response dropped or changed before rready");
    end

endmodule

bind eth_loopback_top eth_loopback_props props_inst (
    .clk(clk),
    .rst_n(rst_n),
    .tx_beat(tx_beat),
    .tx_valid(tx_valid),
    .tx_ready(tx_ready),
    .axil_req(axil_req),
    .axil_rsp(axil_rsp)
);

/* verification/eth_loopback_tb.sv */
// Loopback testbench: random frames through the DUT, scoreboard, counter access and timeout
`timescale 1ns/1ps

module eth_loopback_tb;

import eth_loopback_pkg::*;

localparam logic [31:0] SEED = 32'h9ccf;
localparam int N_GOOD         = 8;
localparam int N_BAD_EACH     = 3;
localparam int N_STALL        = 8;
localparam int OVERSIZE_EXTRA = 40;
// Worst case bytes and frames over all tests
localparam int MAX_BYTES = (N_GOOD + N_STALL + 1) * MAX_FRAME_LEN + FIFO_DEPTH
                         + 2 * MAX_FRAME_LEN
                         + N_BAD_EACH * (3 * MAX_FRAME_LEN + OVERSIZE_EXTRA + MIN_FRAME_LEN);
localparam int MAX_FRAMES = N_GOOD + N_STALL + 4 * N_BAD_EACH + 1
                          + (FIFO_DEPTH + 2 * MAX_FRAME_LEN) / MIN_FRAME_LEN;
// Input plus stalled output per byte, doubled for margin, plus register traffic
localparam int TIMEOUT_CYCLES = 4 * (MAX_BYTES + MAX_FRAMES * (IFG_CYCLES + 4)) + 2000;

logic        clk = 1'b0;
logic        rst_n;
frame_beat_t rx_beat;
logic        rx_valid;
logic        tx_ready = 1'b0;
axil_req_t   axil_req;
frame_beat_t tx_beat;
logic        tx_valid;
axil_rsp_t   axil_rsp;

logic [31:0] rng = SEED;
logic [31:0] ready_rng = SEED;
int          ready_mode = 0;
frame_beat_t exp_q[$];
int          exp_rd = 0;
int          exp_cnt[STAT_COUNT] = '{default: 0};
string       test_name = "reset";
int          errors = 0;
int          out_errors = 0;
int          tests_run = 0;
int          tests_failed = 0;
int          test_start_errors = 0;
int          cycle_count = 0;

always #10 clk = ~clk;

eth_loopback_top UUT (
    .clk(clk),
    .rst_n(rst_n),
    .rx_beat(rx_beat),
    .rx_valid(rx_valid),
    .tx_ready(tx_ready),
    .axil_req(axil_req),
    .tx_beat(tx_beat),
    .tx_valid(tx_valid),
    .axil_rsp(axil_rsp)
);

function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
endfunction

function automatic int rand_range(input int lo, input int hi);
    rng = xorshift(rng);
    return lo + int'(rng % 32'(hi - lo + 1));
endfunction

function automatic int error_total();
    return errors + out_errors + UUT.props_inst.fail_count;
endfunction

// Sink side: 0 holds tx_ready low, 1 high, 2 random
always @(posedge clk) begin
    ready_rng = xorshift(ready_rng);
    #2;
    tx_ready = (ready_mode == 2) ? ready_rng[4] : (ready_mode == 1);
end

// Scoreboard on every accepted output beat
always @(posedge clk) begin
    if (rst_n && tx_valid && tx_ready) begin
        if (exp_rd >= exp_q.size()) begin
            $display("Unexpected output byte %02h in test %s", tx_beat.data, test_name);
            out_errors++;
        end else begin
            assert (tx_beat == exp_q[exp_rd]) else begin
                $display("MISMATCH %s output beat %0d expected %h actual %h",
                         test_name, exp_rd, exp_q[exp_rd], tx_beat);
                out_errors++;
            end
            exp_rd++;
        end
    end
end

always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > TIMEOUT_CYCLES) begin
        $display("Timeout after %0d cycles in test %s", TIMEOUT_CYCLES, test_name);
        $display("Simulation failed");
        $finish;
    end
end

// Sends one frame and updates the model
task automatic send_frame(input int len, input logic bad_in, input logic fits);
    int kind;
    if (len < MIN_FRAME_LEN) begin
        kind = STAT_RX_RUNT;
    end else if (len > MAX_FRAME_LEN) begin
        kind = STAT_RX_OVERSIZE;
    end else if (bad_in) begin
        kind = -1;
    end else begin
        kind = STAT_RX_GOOD;
    end
    if (kind >= 0) begin
        exp_cnt[kind]++;
    end
    if (kind != STAT_RX_GOOD) begin
        exp_cnt[STAT_DROP_BAD]++;
    end else if (!fits) begin
        exp_cnt[STAT_DROP_FULL]++;
    end else begin
        exp_cnt[STAT_TX_FRAME]++;
    end
    for (int i = 0; i < len; i++) begin
        rx_beat.data = 8'(rand_range(0, 255));
        rx_beat.last = i == len - 1;
        rx_beat.bad  = bad_in && i == len - 1;
        rx_valid     = 1'b1;
        if (kind == STAT_RX_GOOD && fits) begin
            exp_q.push_back(rx_beat);
        end
        @(posedge clk);
        #2;
    end
    rx_valid = 1'b0;
    rx_beat  = '0;
    @(posedge clk);
    #2;
endtask

// Waits until a frame of len bytes surely fits in the FIFO
task automatic wait_room(input int len);
    while (exp_q.size() - exp_rd + len > FIFO_DEPTH) begin
        @(posedge clk);
        #2;
    end
endtask

task automatic wait_drain();
    while (exp_rd < exp_q.size()) begin
        @(posedge clk);
        #2;
    end
    // Gap plus checker, FIFO and counter latency
    repeat (IFG_CYCLES + 3) @(posedge clk);
    #2;
endtask

task automatic write_reg(input logic [AXIL_ADDR_W-1:0] addr,
                         input logic [AXIL_DATA_W-1:0] data, output logic [1:0] resp);
    logic aw_done;
    logic w_done;
    aw_done          = 1'b0;
    w_done           = 1'b0;
    axil_req.awaddr  = addr;
    axil_req.awvalid = 1'b1;
    axil_req.wdata   = data;
    axil_req.wstrb   = '1;
    axil_req.wvalid  = 1'b1;
    while (!(aw_done && w_done)) begin
        @(posedge clk);
        aw_done = aw_done || axil_rsp.awready;
        w_done  = w_done || axil_rsp.wready;
        #2;
        axil_req.awvalid = !aw_done;
        axil_req.wvalid  = !w_done;
    end
    while (!axil_rsp.bvalid) begin
        @(posedge clk);
        #2;
    end
    // Hold off bready one cycle so the response has to wait
    @(posedge clk);
    #2;
    axil_req.bready = 1'b1;
    @(posedge clk);
    resp = axil_rsp.bresp;
    #2;
    axil_req.bready = 1'b0;
endtask

task automatic read_reg(input logic [AXIL_ADDR_W-1:0] addr,
                        output logic [AXIL_DATA_W-1:0] data, output logic [1:0] resp);
    logic ar_done;
    ar_done          = 1'b0;
    axil_req.araddr  = addr;
    axil_req.arvalid = 1'b1;
    while (!ar_done) begin
        @(posedge clk);
        ar_done = axil_rsp.arready;
        #2;
        axil_req.arvalid = !ar_done;
    end
    while (!axil_rsp.rvalid) begin
        @(posedge clk);
        #2;
    end
    @(posedge clk);
    #2;
    axil_req.rready = 1'b1;
    @(posedge clk);
    data = axil_rsp.rdata;
    resp = axil_rsp.rresp;
    #2;
    axil_req.rready = 1'b0;
endtask

task automatic check_resp(input logic [1:0] actual, input logic [1:0] expected);
    assert (actual == expected) else begin
        $display("MISMATCH %s response expected %0d actual %0d", test_name, expected, actual);
        errors++;
    end
endtask

task automatic check_counter(input int idx);
    logic [AXIL_DATA_W-1:0] data;
    logic [1:0]             resp;
    read_reg(AXIL_ADDR_W'(idx * 4), data, resp);
    check_resp(resp, RESP_OKAY);
    assert (data == AXIL_DATA_W'(exp_cnt[idx])) else begin
        $display("MISMATCH %s counter %0d expected %0d actual %0d",
                 test_name, idx, exp_cnt[idx], data);
        errors++;
    end
endtask

task automatic clear_counters();
    logic [1:0] resp;
    for (int n = 0; n < STAT_COUNT; n++) begin
        write_reg(AXIL_ADDR_W'(n * 4), '0, resp);
        check_resp(resp, RESP_OKAY);
        exp_cnt[n] = 0;
    end
endtask

task automatic start_test(input string name);
    test_name         = name;
    test_start_errors = error_total();
endtask

task automatic end_test();
    wait_drain();
    for (int n = 0; n < STAT_COUNT; n++) begin
        check_counter(n);
    end
    clear_counters();
    tests_run++;
    if (error_total() == test_start_errors) begin
        $display("Test %s passed", test_name);
    end else begin
        tests_failed++;
        $display("Test %s failed", test_name);
    end
endtask

initial begin
    int                     len;
    int                     sent;
    int                     stored;
    logic [AXIL_DATA_W-1:0] data;
    logic [1:0]             resp;
    rst_n    = 1'b0;
    rx_beat  = '0;
    rx_valid = 1'b0;
    axil_req = '0;
    repeat (3) @(posedge clk);
    #2;
    rst_n      = 1'b1;
    ready_mode = 1;

    start_test("good_frames");
    for (int i = 0; i < N_GOOD; i++) begin
        len = rand_range(MIN_FRAME_LEN, MAX_FRAME_LEN);
        wait_room(len);
        send_frame(len, 1'b0, 1'b1);
    end
    end_test();

    // Input bad, runt, oversize, then a good frame that must still get through
    start_test("bad_frames");
    for (int i = 0; i < N_BAD_EACH; i++) begin
        len = rand_range(MIN_FRAME_LEN, MAX_FRAME_LEN);
        wait_room(len);
        send_frame(len, 1'b1, 1'b1);
        send_frame(rand_range(1, MIN_FRAME_LEN - 1), 1'b0, 1'b1);
        wait_room(MAX_FRAME_LEN);
        send_frame(rand_range(MAX_FRAME_LEN + 1, MAX_FRAME_LEN + OVERSIZE_EXTRA), 1'b0, 1'b1);
        len = rand_range(MIN_FRAME_LEN, MAX_FRAME_LEN);
        wait_room(len);
        send_frame(len, 1'b0, 1'b1);
    end
    end_test();

    // Output stalled, so a frame fits only if the stored bytes leave room
    start_test("fifo_full");
    ready_mode = 0;
    @(posedge clk);
    #2;
    sent   = 0;
    stored = 0;
    while (sent <= FIFO_DEPTH + MAX_FRAME_LEN) begin
        len = rand_range(MIN_FRAME_LEN, MAX_FRAME_LEN);
        send_frame(len, 1'b0, stored + len <= FIFO_DEPTH);
        if (stored + len <= FIFO_DEPTH) begin
            stored += len;
        end
        sent += len;
    end
    repeat (2) @(posedge clk);
    #2;
    ready_mode = 1;
    end_test();

    start_test("gap_and_stall");
    ready_mode = 2;
    for (int i = 0; i < N_STALL; i++) begin
        len = rand_range(MIN_FRAME_LEN, MAX_FRAME_LEN);
        wait_room(len);
        send_frame(len, 1'b0, 1'b1);
    end
    end_test();
    ready_mode = 1;

    start_test("register_access");
    send_frame(rand_range(MIN_FRAME_LEN, MAX_FRAME_LEN), 1'b0, 1'b1);
    wait_drain();
    check_counter(STAT_RX_GOOD);
    write_reg(AXIL_ADDR_W'(STAT_RX_GOOD * 4), '0, resp);
    check_resp(resp, RESP_OKAY);
    exp_cnt[STAT_RX_GOOD] = 0;
    check_counter(STAT_RX_GOOD);
    read_reg(8'h40, data, resp);
    check_resp(resp, RESP_SLVERR);
    assert (data == '0) else begin
        $display("MISMATCH %s unmapped read expected 0 actual %0h", test_name, data);
        errors++;
    end
    write_reg(8'hfc, 32'h1, resp);
    check_resp(resp, RESP_SLVERR);
    end_test();

    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_total());
    if (error_total() == 0) begin
        $display("Simulation completed successfully");
    end else begin
        $display("Simulation failed");
    end
    $finish;
end

endmodule
